/* cab_ctrl.sv */
// ROM loaded tracking, core reset generation with the delayed second pulse, game variant select
// Listens to the download bus and drives the core reset and the variant to the port mux
module cab_ctrl #(
	parameter int RESET_HOLD = 16
) (
	input logic clk_sys,
	input logic arst_n,
	input logic reset_req,
	dl_if.sink dl,
	output logic core_reset,
	output logic rom_loaded,
	output cab_pkg::game_e game
);
	import cab_pkg::*;

	localparam int CNT_W = $clog2(RESET_HOLD + 1);

	logic rom_dl;
	logic rom_dl_q;
	logic hold;
	logic [CNT_W-1:0] hold_cnt;
	byte_t mode;

	assign rom_dl = dl.download && (dl.index == IDX_ROM);
	assign hold = reset_req || !rom_loaded;

	// ==================================================
	// ROM download end and reset generator
	// ==================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rom_dl_q <= 1'b0;
			rom_loaded <= 1'b0;
			hold_cnt <= CNT_W'(RESET_HOLD);
			core_reset <= 1'b1;
		end else begin
			rom_dl_q <= rom_dl;
			if (rom_dl_q && !rom_dl)
				rom_loaded <= 1'b1;
			// Counter parks at zero once the second pulse is out
			if (hold)
				hold_cnt <= CNT_W'(RESET_HOLD);
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
			core_reset <= hold || (hold_cnt == CNT_W'(1));
		end
	end

	// ==================================================
	// Mode byte and variant decode
	// ==================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			mode <= 8'hFF;
			game <= GAME_NONE;
		end else begin
			if (dl.wr && (dl.index == IDX_MODE))
				mode <= dl.data;
			case (mode)
				8'd0: game <= GAME_SPYHUNT;
				8'd1: game <= GAME_TURBO;
				8'd2: game <= GAME_CRATER;
				default: game <= GAME_NONE;
			endcase
		end
	end

	// Second reset pulse lasts one cycle unless a reset request extends it
	a_second_pulse: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$rose(core_reset) && rom_loaded && !$past(reset_req)
		|=> !core_reset || $past(reset_req));

endmodule

/* cab_input_top.sv */
// Cabinet input board top level with plain ports
// Ties the download bus, reset control, DIP store, player merge and port mux together
module cab_input_top #(
	parameter int RESET_HOLD = 16
) (
	input logic clk_sys,
	input logic arst_n,
	input logic reset_req,
	input logic dl_download,
	input logic dl_wr,
	input cab_pkg::byte_t dl_index,
	input logic [cab_pkg::DL_ADDR_W-1:0] dl_addr,
	input cab_pkg::byte_t dl_data,
	input logic [cab_pkg::JOY_W-1:0] joy1,
	input logic [cab_pkg::JOY_W-1:0] joy2,
	input logic [cab_pkg::ANA_W-1:0] stick1,
	input logic [cab_pkg::ANA_W-1:0] stick2,
	input logic [cab_pkg::SPIN_W-1:0] spin1,
	input logic [cab_pkg::SPIN_W-1:0] spin2,
	input logic [cab_pkg::PAD_W-1:0] pad1,
	input logic [cab_pkg::PAD_W-1:0] pad2,
	input logic steer_sel,
	input logic steer_paddle,
	output logic core_reset,
	output logic rom_loaded,
	output cab_pkg::byte_t input_0,
	output cab_pkg::byte_t input_1,
	output cab_pkg::byte_t input_2,
	output cab_pkg::byte_t input_3,
	output cab_pkg::byte_t input_4,
	output logic landscape
);
	import cab_pkg::*;

	dl_if dl ();

	game_e game;
	byte_t dip0;
	logic service;
	ctrl_t ctrl;
	logic [ANA_W-1:0] stick;
	logic [SPIN_W-1:0] spin;
	logic [PAD_W-1:0] pad;

	// Download bus from the loader ports
	assign dl.download = dl_download;
	assign dl.wr = dl_wr;
	assign dl.index = dl_index;
	assign dl.addr = dl_addr;
	assign dl.data = dl_data;

	cab_ctrl #(.RESET_HOLD(RESET_HOLD)) u_cab_ctrl (
		.clk_sys(clk_sys), .arst_n(arst_n), .reset_req(reset_req), .dl(dl.sink),
		.core_reset(core_reset), .rom_loaded(rom_loaded), .game(game)
	);

	dip_bank u_dip_bank (
		.clk_sys(clk_sys), .arst_n(arst_n), .dl(dl.sink), .dip0(dip0), .service(service)
	);

	player_merge u_player_merge (
		.clk_sys(clk_sys), .arst_n(arst_n), .joy1(joy1), .joy2(joy2),
		.stick1(stick1), .stick2(stick2), .ctrl(ctrl), .stick(stick)
	);

	recent_source_sel #(.payload_t(logic [SPIN_W-1:0])) u_spin_sel (
		.clk_sys(clk_sys), .arst_n(arst_n), .src_a(spin1), .src_b(spin2), .chosen(spin)
	);

	recent_source_sel #(.payload_t(logic [PAD_W-1:0])) u_pad_sel (
		.clk_sys(clk_sys), .arst_n(arst_n), .src_a(pad1), .src_b(pad2), .chosen(pad)
	);

	port_mux u_port_mux (
		.clk_sys(clk_sys), .arst_n(arst_n), .steer_sel(steer_sel),
		.steer_paddle(steer_paddle), .game(game), .ctrl(ctrl), .stick(stick),
		.spin(spin), .pad(pad), .dip0(dip0), .service(service),
		.input_0(input_0), .input_1(input_1), .input_2(input_2),
		.input_3(input_3), .input_4(input_4), .landscape(landscape)
	);

endmodule

/* cab_pkg.sv */
// Shared widths, download indices, game variants and control bundle for the cabinet input board
// Imported by every RTL module of the board
package cab_pkg;

	typedef logic [7:0] byte_t;

	// Joystick word bits, LSB first: right, left, down, up, fire a-e, shift, coin, start
	localparam int JOY_W = 12;
	// Analog stick word, X in the low byte and Y in the high byte, both signed
	localparam int ANA_W = 16;
	localparam int SPIN_W = 9;
	localparam int PAD_W = 8;

	localparam int DL_ADDR_W = 25;
	localparam byte_t IDX_ROM = 8'd0;
	localparam byte_t IDX_MODE = 8'd1;
	localparam byte_t IDX_DIP = 8'd254;
	localparam int DIP_BYTES = 8;

	typedef enum logic [1:0] {
		GAME_SPYHUNT = 2'd0,
		GAME_TURBO = 2'd1,
		GAME_CRATER = 2'd2,
		GAME_NONE = 2'd3
	} game_e;

	// Merged cabinet controls, active high
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic fire_a;
		logic fire_b;
		logic fire_c;
		logic fire_d;
		logic fire_e;
		logic shift;
		logic coin;
	} ctrl_t;

	localparam byte_t STEER_CENTER = 8'h70;

endpackage

/* compile.f */
cab_pkg.sv
download_if.sv
cab_ctrl.sv
dip_bank.sv
recent_source_sel.sv
player_merge.sv
port_mux.sv
cab_input_top.sv
tb_checker.sv
tb_top.sv

/* dip_bank.sv */
// Eight DIP switch bytes loaded over the download bus
// Exposes the game DIP byte and the service switch
module dip_bank (
	input logic clk_sys,
	input logic arst_n,
	dl_if.sink dl,
	output cab_pkg::byte_t dip0,
	output logic service
);
	import cab_pkg::*;

	localparam int SEL_W = $clog2(DIP_BYTES);

	byte_t [DIP_BYTES-1:0] dip;
	logic dip_we;

	assign dip_we = dl.wr && (dl.index == IDX_DIP) && (dl.addr < DL_ADDR_W'(DIP_BYTES));

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			dip <= '0;
		else if (dip_we)
			dip[dl.addr[SEL_W-1:0]] <= dl.data;
	end

	assign dip0 = dip[0];
	// Service switch sits in bit 0 of the second byte
	assign service = dip[1][0];

	a_dip_addr: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(dip != $past(dip)) |-> $past(dl.wr && dl.addr < DL_ADDR_W'(DIP_BYTES)));

endmodule

/* download_if.sv */
// ROM and configuration download bus shared by the board's control blocks
// The top level drives it, the control and DIP blocks listen
interface dl_if;
	import cab_pkg::*;

	logic download;
	logic wr;
	byte_t index;
	logic [DL_ADDR_W-1:0] addr;
	byte_t data;

	modport source (
		output download, wr, index, addr, data
	);

	modport sink (
		input download, wr, index, addr, data
	);

endinterface

/* player_merge.sv */
// Merges both players' joysticks into the cabinet controls
// Tracks the last active player and hands on that player's analog stick
module player_merge (
	input logic clk_sys,
	input logic arst_n,
	input logic [cab_pkg::JOY_W-1:0] joy1,
	input logic [cab_pkg::JOY_W-1:0] joy2,
	input logic [cab_pkg::ANA_W-1:0] stick1,
	input logic [cab_pkg::ANA_W-1:0] stick2,
	output cab_pkg::ctrl_t ctrl,
	output logic [cab_pkg::ANA_W-1:0] stick
);
	import cab_pkg::*;

	logic [JOY_W-1:0] joy;
	logic p2_live;

	assign joy = joy1 | joy2;

	always_comb begin
		ctrl.right = joy[0];
		ctrl.left = joy[1];
		ctrl.down = joy[2];
		ctrl.up = joy[3];
		ctrl.fire_a = joy[4];
		ctrl.fire_b = joy[5];
		ctrl.fire_c = joy[6];
		ctrl.fire_d = joy[7];
		ctrl.fire_e = joy[8];
		ctrl.shift = joy[9];
		ctrl.coin = joy[10];
	end

	// Player 1 activity overrides player 2 on the same cycle
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			p2_live <= 1'b0;
		else if (joy1 != '0)
			p2_live <= 1'b0;
		else if (joy2 != '0)
			p2_live <= 1'b1;
	end

	assign stick = p2_live ? stick2 : stick1;

endmodule

/* port_mux.sv */
// Builds the five active low game input ports and the landscape flag
// Layout follows the running variant, all outputs registered
module port_mux (
	input logic clk_sys,
	input logic arst_n,
	input logic steer_sel,
	input logic steer_paddle,
	input cab_pkg::game_e game,
	input cab_pkg::ctrl_t ctrl,
	input logic [cab_pkg::ANA_W-1:0] stick,
	input logic [cab_pkg::SPIN_W-1:0] spin,
	input logic [cab_pkg::PAD_W-1:0] pad,
	input cab_pkg::byte_t dip0,
	input logic service,
	output cab_pkg::byte_t input_0,
	output cab_pkg::byte_t input_1,
	output cab_pkg::byte_t input_2,
	output cab_pkg::byte_t input_3,
	output cab_pkg::byte_t input_4,
	output logic landscape
);
	import cab_pkg::*;

	byte_t stick_x;
	byte_t stick_y;
	byte_t steer;
	byte_t gas_raw;
	byte_t analog;
	byte_t in0_d;
	byte_t in1_d;
	byte_t in2_d;
	logic land_d;

	// ==================================================
	// Analog steering and gas
	// ==================================================
	assign stick_x = stick[7:0];
	assign stick_y = stick[15:8];

	assign steer = steer_paddle ?
		STEER_CENTER + {~pad[7], ~pad[7], pad[6:1]} :
		STEER_CENTER + {stick_x[7], stick_x[7:1]};

	// Pulling back is gas on every game, pushing forward only on Turbo
	assign gas_raw = stick_y[7] ? 8'h00 - stick_y :
		(game == GAME_TURBO) ? stick_y : 8'h00;

	assign analog = steer_sel ? steer : {gas_raw[6:0], 1'b1};

	// ==================================================
	// Per variant port layout
	// ==================================================
	always_comb begin
		in0_d = 8'hFF;
		in1_d = 8'hFF;
		in2_d = 8'hFF;
		land_d = 1'b0;
		case (game)
			GAME_SPYHUNT: begin
				in0_d = ~{service, 2'b00, ctrl.shift, 3'b000, ctrl.coin};
				in1_d = ~{3'b000, ctrl.fire_a, ctrl.fire_c, ctrl.fire_e, ctrl.fire_b, ctrl.fire_d};
				in2_d = analog;
			end
			GAME_TURBO: begin
				// Gear shift follows the stick direction
				in0_d = ~{service, 2'b00, ~stick_y[7], 3'b000, ctrl.coin};
				in1_d = ~{3'b000, ctrl.fire_e, ctrl.fire_d, ctrl.fire_c, ctrl.fire_b, ctrl.fire_a};
				in2_d = analog;
			end
			GAME_CRATER: begin
				in0_d = ~{service, 2'b00, ctrl.fire_a, ctrl.fire_e, ctrl.shift, 1'b0, ctrl.coin};
				in1_d = spin[7:0];
				in2_d = ~{1'b0, ctrl.fire_b, 1'b0, ctrl.fire_c, ctrl.down, ctrl.up, 2'b00};
				land_d = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			input_0 <= 8'hFF;
			input_1 <= 8'hFF;
			input_2 <= 8'hFF;
			input_3 <= 8'h00;
			input_4 <= 8'hFF;
			landscape <= 1'b0;
		end else begin
			input_0 <= in0_d;
			input_1 <= in1_d;
			input_2 <= in2_d;
			input_3 <= dip0;
			input_4 <= 8'hFF;
			landscape <= land_d;
		end
	end

	a_landscape: assert property (@(posedge clk_sys) disable iff (!arst_n)
		landscape |-> $past(game) == GAME_CRATER);

endmodule

/* recent_source_sel.sv */
// Picks whichever of two input sources changed most recently, source b wins a tie
// Used for the spinner pair and the paddle pair
module recent_source_sel #(
	parameter type payload_t = logic [7:0]
) (
	input logic clk_sys,
	input logic arst_n,
	input payload_t src_a,
	input payload_t src_b,
	output payload_t chosen
);

	payload_t a_q;
	payload_t b_q;
	logic sel_b;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			a_q <= '0;
			b_q <= '0;
			sel_b <= 1'b0;
			chosen <= '0;
		end else begin
			a_q <= src_a;
			b_q <= src_b;
			// B checked first so it takes a simultaneous change
			if (b_q != src_b)
				sel_b <= 1'b1;
			else if (a_q != src_a)
				sel_b <= 1'b0;
			chosen <= sel_b ? b_q : a_q;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message in its output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f compile.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" || exit 1

/* tb_checker.sv */
// Watches the cabinet input board pins, models the port rules and counts errors
// Ports are compared on each check strobe, the reset sequence on every cycle
module tb_checker #(
	parameter int RESET_HOLD = 16
) (
	input logic clk_sys, arst_n, reset_req, dl_download, dl_wr,
	input cab_pkg::byte_t dl_index, dl_data,
	input logic [cab_pkg::DL_ADDR_W-1:0] dl_addr,
	input logic [cab_pkg::JOY_W-1:0] joy1, joy2,
	input logic [cab_pkg::ANA_W-1:0] stick1, stick2,
	input logic [cab_pkg::SPIN_W-1:0] spin1, spin2,
	input logic [cab_pkg::PAD_W-1:0] pad1, pad2,
	input logic steer_sel, steer_paddle, core_reset, rom_loaded, landscape,
	input cab_pkg::byte_t input_0, input_1, input_2, input_3, input_4,
	input logic check_en, end_check, exp_land,
	output int mismatches, failures
);
	timeunit 1ns;
	timeprecision 100ps;
	import cab_pkg::*;

	byte_t mode, dip0, dip1;
	logic p2_live, spin_b, pad_b, req_prev, req_seen, first_low, core_prev;
	logic exp_rom, rom_dl_prev;
	logic [SPIN_W-1:0] spin1_q, spin2_q;
	logic [PAD_W-1:0] pad1_q, pad2_q;
	int pulses, since_low;

	task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			mismatches++;
		end
	endtask

	task automatic report_fail(input string what);
		$display("ERROR at %0d ns: %s", $time, what);
		failures++;
	endtask

	// ==================================================
	// Expected ports from the layout rules
	// ==================================================
	task automatic compare_ports();
		logic [JOY_W-1:0] j;
		logic [ANA_W-1:0] st;
		byte_t sx, sy, pad, steer, gas, ana, e0, e1, e2;
		j = joy1 | joy2;
		st = p2_live ? stick2 : stick1;
		sx = st[7:0];
		sy = st[15:8];
		pad = pad_b ? pad2 : pad1;
		if (steer_paddle)
			steer = STEER_CENTER + {~pad[7], ~pad[7], pad[6:1]};
		else
			steer = STEER_CENTER + byte_t'($signed(sx) >>> 1);
		if (sy[7])
			gas = 8'h00 - sy;
		else
			gas = (mode == 8'd1) ? sy : 8'h00;
		ana = steer_sel ? steer : {gas[6:0], 1'b1};
		{e0, e1, e2} = {3{8'hFF}};
		case (mode)
			8'd0, 8'd1: begin
				e0 = ~{dip1[0], 2'b00, ((mode == 8'd1) ? ~sy[7] : j[9]), 3'b000, j[10]};
				if (mode == 8'd1)
					e1 = ~{3'b000, j[8], j[7], j[6], j[5], j[4]};
				else
					e1 = ~{3'b000, j[4], j[6], j[8], j[5], j[7]};
				e2 = ana;
			end
			8'd2: begin
				e0 = ~{dip1[0], 2'b00, j[4], j[8], j[9], 1'b0, j[10]};
				e1 = spin_b ? spin2[7:0] : spin1[7:0];
				e2 = ~{1'b0, j[5], 1'b0, j[6], j[2], j[3], 2'b00};
			end
			default: ;
		endcase
		compare_byte("input_0", input_0, e0);
		compare_byte("input_1", input_1, e1);
		compare_byte("input_2", input_2, e2);
		compare_byte("input_3", input_3, dip0);
		compare_byte("input_4", input_4, 8'hFF);
		compare_byte("landscape", byte_t'(landscape), byte_t'(exp_land));
	endtask

	// Outputs settle after the rising edge, so everything is sampled on the falling one
	always @(negedge clk_sys) begin
		if (!arst_n) begin
			{mode, dip0, dip1} = {8'hFF, 8'h00, 8'h00};
			{p2_live, spin_b, pad_b, req_prev, req_seen, first_low} = '0;
			{exp_rom, rom_dl_prev} = '0;
			core_prev = 1'b1;
			{spin1_q, spin2_q, pad1_q, pad2_q} = '0;
			{pulses, since_low, mismatches, failures} = '0;
		end else begin
			if (check_en)
				compare_ports();
			compare_byte("rom_loaded", byte_t'(rom_loaded), byte_t'(exp_rom));
			if (req_prev && !core_reset)
				report_fail("core_reset low while reset_req was asserted");
			if (!req_seen && !exp_rom && !core_reset)
				report_fail("core_reset low before the ROM download ended");
			// Second pulse tracking stops at the first reset request
			if (!req_seen && exp_rom) begin
				if (first_low)
					since_low++;
				else if (!core_reset)
					first_low = 1'b1;
				if (first_low && core_reset && core_prev)
					report_fail("second reset pulse longer than one cycle");
				if (first_low && core_reset && !core_prev) begin
					pulses++;
					if (since_low > RESET_HOLD)
						report_fail("second reset pulse came too late");
				end
			end
			if (end_check && pulses != 1)
				report_fail($sformatf("expected one second reset pulse, saw %0d", pulses));
			if (end_check && !rom_loaded)
				report_fail("rom_loaded low at the end of the run");
			// Loaded flag rises one cycle after the ROM download falls
			if (rom_dl_prev && !(dl_download && dl_index == IDX_ROM))
				exp_rom = 1'b1;
			rom_dl_prev = dl_download && (dl_index == IDX_ROM);
			// Models of the download registers and the source pickers
			if (dl_wr && dl_index == IDX_MODE)
				mode = dl_data;
			if (dl_wr && dl_index == IDX_DIP && dl_addr == 25'd0)
				dip0 = dl_data;
			if (dl_wr && dl_index == IDX_DIP && dl_addr == 25'd1)
				dip1 = dl_data;
			if (joy1 != '0)
				p2_live = 1'b0;
			else if (joy2 != '0)
				p2_live = 1'b1;
			if (spin2 != spin2_q)
				spin_b = 1'b1;
			else if (spin1 != spin1_q)
				spin_b = 1'b0;
			if (pad2 != pad2_q)
				pad_b = 1'b1;
			else if (pad1 != pad1_q)
				pad_b = 1'b0;
			{spin1_q, spin2_q, pad1_q, pad2_q} = {spin1, spin2, pad1, pad2};
			req_prev = reset_req;
			req_seen = req_seen | reset_req;
			core_prev = core_reset;
		end
	end

endmodule

/* tb_top.sv */
// Testbench top for the cabinet input board: ROM download, the stimulus table and a reset
// request, then prints the result that tb_checker has counted
module tb_top;
	timeunit 1ns;
	timeprecision 100ps;
	import cab_pkg::*;

	localparam int RESET_HOLD = 16;
	localparam int NROWS = 10;
	localparam int LIMIT = NROWS * 12 + 200;

	// Row fields: mode, DIP bytes 0 and 1, pressing players {p2, p1}, sticks, spinners,
	// paddles, steering select, paddle steering, expected landscape
	typedef struct packed {
		byte_t mode;
		byte_t dip0;
		byte_t dip1;
		logic [1:0] press;
		logic [ANA_W-1:0] stick1;
		logic [ANA_W-1:0] stick2;
		logic [SPIN_W-1:0] spin1;
		logic [SPIN_W-1:0] spin2;
		logic [PAD_W-1:0] pad1;
		logic [PAD_W-1:0] pad2;
		logic steer_sel;
		logic steer_paddle;
		logic exp_land;
	} row_t;

	logic clk_sys = 1'b0;
	logic arst_n, reset_req, dl_download, dl_wr, steer_sel, steer_paddle;
	byte_t dl_index, dl_data;
	logic [DL_ADDR_W-1:0] dl_addr;
	logic [JOY_W-1:0] joy1, joy2;
	logic [ANA_W-1:0] stick1, stick2;
	logic [SPIN_W-1:0] spin1, spin2;
	logic [PAD_W-1:0] pad1, pad2;
	logic core_reset, rom_loaded, landscape, check_en, end_check, exp_land;
	byte_t input_0, input_1, input_2, input_3, input_4;
	int mismatches, failures, cycles;
	row_t rows [NROWS];

	always #2 clk_sys = ~clk_sys;

	cab_input_top #(.RESET_HOLD(RESET_HOLD)) DUT (.*);
	tb_checker #(.RESET_HOLD(RESET_HOLD)) u_checker (.*);

	// One download write, called 1 ns after a rising edge
	task automatic dl_write(input byte_t idx, input logic [DL_ADDR_W-1:0] addr,
		input byte_t data);
		dl_wr = 1'b1;
		dl_index = idx;
		dl_addr = addr;
		dl_data = data;
		@(posedge clk_sys);
		#1 dl_wr = 1'b0;
	endtask

	task automatic apply_row(input row_t r);
		joy1 = r.press[0] ? (JOY_W'($urandom) | 12'h010) : '0;
		joy2 = r.press[1] ? (JOY_W'($urandom) | 12'h010) : '0;
		{stick1, stick2, spin1, spin2} = {r.stick1, r.stick2, r.spin1, r.spin2};
		{pad1, pad2, exp_land} = {r.pad1, r.pad2, r.exp_land};
		{steer_sel, steer_paddle} = {r.steer_sel, r.steer_paddle};
		dl_write(IDX_MODE, 25'd0, r.mode);
		dl_write(IDX_DIP, 25'd0, r.dip0);
		dl_write(IDX_DIP, 25'd1, r.dip1);
		// Out of range, aliases bytes 0 and 1 if the address guard is missing
		dl_write(IDX_DIP, 25'd8, ~r.dip0);
		dl_write(IDX_DIP, 25'd9, ~r.dip1);
		repeat (8) @(posedge clk_sys);
		#1 check_en = 1'b1;
		@(posedge clk_sys);
		#1 check_en = 1'b0;
	endtask

	// ==================================================
	// Stimulus
	// ==================================================
	initial begin
		void'($urandom(32'h6774));
		{arst_n, reset_req, dl_download, dl_wr, steer_sel, steer_paddle} = '0;
		{check_en, end_check, exp_land} = '0;
		{dl_index, dl_data, dl_addr} = '0;
		{joy1, joy2, stick1, stick2} = '0;
		{spin1, spin2, pad1, pad2} = '0;
		rows[0] = '{8'd0, 8'h5A, 8'h01, 2'b01, 16'hF030, 16'h1080, 9'h000, 9'h000,
			8'h00, 8'h00, 1'b1, 1'b0, 1'b0};
		rows[1] = '{8'd0, 8'h3C, 8'h00, 2'b10, 16'h2010, 16'hE0C0, 9'h000, 9'h000,
			8'h00, 8'h00, 1'b0, 1'b0, 1'b0};
		rows[2] = '{8'd1, 8'hA5, 8'h01, 2'b11, 16'h3044, 16'h9000, 9'h000, 9'h000,
			8'h00, 8'h00, 1'b0, 1'b0, 1'b0};
		rows[3] = '{8'd1, 8'hA5, 8'h00, 2'b00, 16'hC0FE, 16'h7001, 9'h000, 9'h000,
			8'h9A, 8'h00, 1'b1, 1'b1, 1'b0};
		rows[4] = '{8'd2, 8'h0F, 8'h01, 2'b10, 16'h4000, 16'h8822, 9'h123, 9'h000,
			8'h9A, 8'h00, 1'b0, 1'b0, 1'b1};
		rows[5] = '{8'd2, 8'h0F, 8'h00, 2'b01, 16'h4000, 16'h8822, 9'h123, 9'h1A5,
			8'h9A, 8'h00, 1'b0, 1'b0, 1'b1};
		rows[6] = '{8'd2, 8'hF0, 8'h01, 2'b11, 16'h4000, 16'h8822, 9'h0C7, 9'h0FE,
			8'h9A, 8'h00, 1'b1, 1'b0, 1'b1};
		rows[7] = '{8'd5, 8'h77, 8'h01, 2'b11, 16'h4000, 16'h8822, 9'h0C7, 9'h0FE,
			8'h9A, 8'h00, 1'b1, 1'b0, 1'b0};
		rows[8] = '{8'd0, 8'h81, 8'h00, 2'b01, 16'h4000, 16'h8822, 9'h0C7, 9'h0FE,
			8'h9A, 8'h4C, 1'b1, 1'b1, 1'b0};
		rows[9] = '{8'd0, 8'h18, 8'h01, 2'b10, 16'h4000, 16'h2511, 9'h0C7, 9'h0FE,
			8'h9A, 8'h4C, 1'b0, 1'b0, 1'b0};
		repeat (2) @(posedge clk_sys);
		#1 arst_n = 1'b1;
		repeat (3) @(posedge clk_sys);
		// Short ROM download, core held in reset until it ends
		#1 dl_download = 1'b1;
		for (int i = 0; i < 4; i++)
			dl_write(IDX_ROM, DL_ADDR_W'(i), byte_t'($urandom));
		dl_download = 1'b0;
		while (!rom_loaded) begin
			@(posedge clk_sys);
			#1;
		end
		for (int r = 0; r < NROWS; r++)
			apply_row(rows[r]);
		reset_req = 1'b1;
		repeat (3) @(posedge clk_sys);
		#1 reset_req = 1'b0;
		end_check = 1'b1;
		@(posedge clk_sys);
		#1 end_check = 1'b0;
		@(posedge clk_sys);
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", LIMIT);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule
